//--- source/tracker_pkg.sv
`default_nettype none

package tracker_pkg;

    localparam int COORD_W     = 11;   // Wide enough for 1280x720 rasters
    localparam int SCALE_SHIFT = 2;    // Buffer holds one word per 4x4 block

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } pixel565_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    typedef struct packed {
        logic               valid;
        logic [COORD_W-1:0] hcount;
        logic [COORD_W-1:0] vcount;
        pixel565_t          pixel;
    } cam_pixel_t;

    typedef struct packed {
        logic [COORD_W-1:0] hcount;
        logic [COORD_W-1:0] vcount;
        logic               hsync;
        logic               vsync;
        logic               active;
        logic               new_frame;  // First cycle of a frame, at (0,0)
    } video_timing_t;

    typedef struct packed {
        video_timing_t timing;
        rgb888_t       rgb;      // Expanded camera colour
        logic [7:0]    value;    // Selected channel
        logic          mask;
    } classified_t;

    typedef struct packed {
        video_timing_t timing;
        rgb888_t       rgb;
    } video_out_t;

    typedef enum logic [1:0] {CH_RED, CH_GREEN, CH_BLUE} channel_e;

    typedef enum logic [1:0] {VIEW_CAMERA, VIEW_CHANNEL, VIEW_MASK} view_e;

    typedef enum logic [1:0] {DIV_IDLE, DIV_X, DIV_Y, DIV_DONE} div_state_e;

endpackage

`default_nettype wire

//--- source/video_timing.sv
`timescale 1ns/1ns
`default_nettype none

module video_timing #(
    parameter int H_ACTIVE = 64,
    parameter int H_FRONT  = 4,
    parameter int H_SYNC   = 8,
    parameter int H_BACK   = 4,
    parameter int V_ACTIVE = 32,
    parameter int V_FRONT  = 2,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 2
) (
    input  wire                        clk_pixel,
    input  wire                        recent_reset,
    output tracker_pkg::video_timing_t timing_o
);
    import tracker_pkg::*;

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    localparam logic [COORD_W-1:0] H_LAST     = COORD_W'(H_TOTAL - 1);
    localparam logic [COORD_W-1:0] V_LAST     = COORD_W'(V_TOTAL - 1);
    localparam logic [COORD_W-1:0] H_ACT_END  = COORD_W'(H_ACTIVE);
    localparam logic [COORD_W-1:0] V_ACT_END  = COORD_W'(V_ACTIVE);
    localparam logic [COORD_W-1:0] HS_START   = COORD_W'(H_ACTIVE + H_FRONT);
    localparam logic [COORD_W-1:0] HS_END     = COORD_W'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam logic [COORD_W-1:0] VS_START   = COORD_W'(V_ACTIVE + V_FRONT);
    localparam logic [COORD_W-1:0] VS_END     = COORD_W'(V_ACTIVE + V_FRONT + V_SYNC);

    logic [COORD_W-1:0] h_cnt;
    logic [COORD_W-1:0] v_cnt;

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            h_cnt    <= '0;
            v_cnt    <= '0;
            timing_o <= '0;
        end else begin
            // Outputs describe the position the counters hold now
            timing_o.hcount    <= h_cnt;
            timing_o.vcount    <= v_cnt;
            timing_o.hsync     <= (h_cnt >= HS_START) && (h_cnt < HS_END);
            timing_o.vsync     <= (v_cnt >= VS_START) && (v_cnt < VS_END);
            timing_o.active    <= (h_cnt < H_ACT_END) && (v_cnt < V_ACT_END);
            timing_o.new_frame <= (h_cnt == '0) && (v_cnt == '0);

            if (h_cnt == H_LAST) begin
                h_cnt <= '0;
                v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;  // Wrap at frame end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/frame_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module frame_buffer #(
    parameter int H_ACTIVE = 64,
    parameter int V_ACTIVE = 32
) (
    input  wire                             clk_pixel,
    input  wire                             recent_reset,
    input  wire tracker_pkg::cam_pixel_t    cam_i,
    input  wire tracker_pkg::video_timing_t timing_i,
    output tracker_pkg::video_timing_t      timing_o,
    output tracker_pkg::pixel565_t          pixel_o
);
    import tracker_pkg::*;

    localparam int ROW_WORDS = H_ACTIVE >> SCALE_SHIFT;
    localparam int DEPTH     = ROW_WORDS * (V_ACTIVE >> SCALE_SHIFT);
    localparam int ADDR_W    = $clog2(DEPTH);

    // Word address of the 4x4 block holding a full-resolution coordinate
    function automatic logic [ADDR_W-1:0] block_addr(input logic [COORD_W-1:0] h,
                                                     input logic [COORD_W-1:0] v);
        logic [COORD_W-1:0] col;
        logic [COORD_W-1:0] row;
        col = h >> SCALE_SHIFT;
        row = v >> SCALE_SHIFT;
        return ADDR_W'(col) + ADDR_W'(row) * ADDR_W'(ROW_WORDS);
    endfunction

    pixel565_t          mem [0:DEPTH-1];
    logic               wr_en;
    logic [ADDR_W-1:0]  rd_addr;
    video_timing_t      timing_d1;

    // Keep only the top-left pixel of every 4x4 block
    assign wr_en = cam_i.valid
                && (cam_i.hcount[1:0] == 2'b00) && (cam_i.vcount[1:0] == 2'b00)
                && (cam_i.hcount < COORD_W'(H_ACTIVE)) && (cam_i.vcount < COORD_W'(V_ACTIVE));

    always_ff @(posedge clk_pixel) begin
        if (wr_en) begin
            mem[block_addr(cam_i.hcount, cam_i.vcount)] <= cam_i.pixel;
        end
    end

    // Read stage 1 registers the address, stage 2 the memory word
    always_ff @(posedge clk_pixel) begin
        rd_addr <= timing_i.active ? block_addr(timing_i.hcount, timing_i.vcount) : '0;
        pixel_o <= timing_d1.active ? mem[rd_addr] : '0;  // Black outside the picture
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            timing_d1 <= '0;
            timing_o  <= '0;
        end else begin
            timing_d1 <= timing_i;
            timing_o  <= timing_d1;
        end
    end

endmodule

`default_nettype wire

//--- source/pixel_classifier.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_classifier (
    input  wire                             clk_pixel,
    input  wire                             recent_reset,
    input  wire tracker_pkg::video_timing_t timing_i,
    input  wire tracker_pkg::pixel565_t     pixel_i,
    input  wire tracker_pkg::channel_e      channel_i,
    input  wire [7:0]                       lower_i,
    input  wire [7:0]                       upper_i,
    output tracker_pkg::classified_t        class_o
);
    import tracker_pkg::*;

    rgb888_t    expanded;
    logic [7:0] value;
    logic       in_window;

    always_comb begin
        // Low bits left at zero
        expanded.r = {pixel_i.r, 3'b000};
        expanded.g = {pixel_i.g, 2'b00};
        expanded.b = {pixel_i.b, 3'b000};

        case (channel_i)
            CH_RED:   value = expanded.r;
            CH_GREEN: value = expanded.g;
            CH_BLUE:  value = expanded.b;
            default:  value = '0;
        endcase

        in_window = (value >= lower_i) && (value <= upper_i);  // Both bounds inclusive
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            class_o <= '0;
        end else begin
            class_o.timing <= timing_i;
            class_o.rgb    <= expanded;
            class_o.value  <= value;
            class_o.mask   <= timing_i.active && in_window;
        end
    end

endmodule

`default_nettype wire

//--- source/centroid_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module centroid_tracker (
    input  wire                             clk_pixel,
    input  wire                             recent_reset,
    input  wire tracker_pkg::classified_t   class_i,
    output logic [tracker_pkg::COORD_W-1:0] com_x_o,
    output logic [tracker_pkg::COORD_W-1:0] com_y_o
);
    import tracker_pkg::*;

    localparam int CNT_W  = 2 * COORD_W;        // Pixel count of a full raster
    localparam int SUM_W  = CNT_W + COORD_W;    // Count times largest coordinate
    localparam int STEP_W = $clog2(COORD_W);

    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(COORD_W - 1);

    div_state_e         state;
    logic [SUM_W-1:0]   sum_x;
    logic [SUM_W-1:0]   sum_y;
    logic [CNT_W-1:0]   cnt;
    logic [SUM_W-1:0]   x_add;
    logic [SUM_W-1:0]   y_add;
    logic [CNT_W-1:0]   c_add;

    logic [SUM_W-1:0]   snap_y;
    logic [CNT_W-1:0]   snap_cnt;
    logic [SUM_W-1:0]   rem;
    logic [SUM_W-1:0]   div_sh;     // Divisor aligned to the current quotient bit
    logic [COORD_W-1:0] quot;
    logic [COORD_W-1:0] res_x;
    logic [STEP_W-1:0]  step;
    logic [SUM_W-1:0]   rem_next;
    logic [COORD_W-1:0] quot_next;

    always_comb begin
        x_add = class_i.mask ? SUM_W'(class_i.timing.hcount) : '0;
        y_add = class_i.mask ? SUM_W'(class_i.timing.vcount) : '0;
        c_add = CNT_W'(class_i.mask);
    end

    // Per-frame sums; the first pixel of a frame starts the new totals
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            sum_x <= '0;
            sum_y <= '0;
            cnt   <= '0;
        end else if (class_i.timing.new_frame) begin
            sum_x <= x_add;
            sum_y <= y_add;
            cnt   <= c_add;
        end else begin
            sum_x <= sum_x + x_add;
            sum_y <= sum_y + y_add;
            cnt   <= cnt + c_add;
        end
    end

    // One restoring step: subtract when the shifted divisor fits
    always_comb begin
        if (rem >= div_sh) begin
            rem_next  = rem - div_sh;
            quot_next = {quot[COORD_W-2:0], 1'b1};
        end else begin
            rem_next  = rem;
            quot_next = {quot[COORD_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            state   <= DIV_IDLE;
            step    <= '0;
            com_x_o <= '0;
            com_y_o <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (class_i.timing.new_frame) begin
                        snap_y   <= sum_y;
                        snap_cnt <= cnt;
                        rem      <= sum_x;
                        div_sh   <= SUM_W'(cnt) << (COORD_W - 1);
                        quot     <= '0;
                        step     <= '0;
                        state    <= (cnt == '0) ? DIV_DONE : DIV_X;  // Empty frame skips division
                    end
                end
                DIV_X: begin
                    step   <= step + 1'b1;
                    rem    <= rem_next;
                    quot   <= quot_next;
                    div_sh <= div_sh >> 1;
                    if (step == LAST_STEP) begin
                        res_x  <= quot_next;
                        rem    <= snap_y;
                        div_sh <= SUM_W'(snap_cnt) << (COORD_W - 1);
                        quot   <= '0;
                        step   <= '0;
                        state  <= DIV_Y;
                    end
                end
                DIV_Y: begin
                    step   <= step + 1'b1;
                    rem    <= rem_next;
                    quot   <= quot_next;
                    div_sh <= div_sh >> 1;
                    if (step == LAST_STEP) begin
                        state <= DIV_DONE;
                    end
                end
                DIV_DONE: begin
                    if (snap_cnt != '0) begin
                        com_x_o <= res_x;
                        com_y_o <= quot;
                    end
                    state <= DIV_IDLE;
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/display_mux.sv
`timescale 1ns/1ns
`default_nettype none

module display_mux (
    input  wire                             clk_pixel,
    input  wire                             recent_reset,
    input  wire tracker_pkg::classified_t   class_i,
    input  wire [tracker_pkg::COORD_W-1:0]  com_x_i,
    input  wire [tracker_pkg::COORD_W-1:0]  com_y_i,
    input  wire tracker_pkg::view_e         view_i,
    input  wire                             crosshair_en_i,
    output tracker_pkg::video_out_t         video_o
);
    import tracker_pkg::*;

    rgb888_t rgb;
    logic    on_cross;

    assign on_cross = crosshair_en_i
                   && ((class_i.timing.hcount == com_x_i) || (class_i.timing.vcount == com_y_i));

    always_comb begin
        case (view_i)
            VIEW_CAMERA:  rgb = class_i.rgb;
            VIEW_CHANNEL: rgb = {class_i.value, class_i.value, class_i.value};  // Grey scale
            VIEW_MASK:    rgb = class_i.mask ? 24'hFFFFFF : 24'h000000;
            default:      rgb = '0;
        endcase

        if (on_cross) begin
            rgb = 24'hFFFFFF;
        end

        // Blanking wins over everything
        if (!class_i.timing.active) begin
            rgb = '0;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            video_o <= '0;
        end else begin
            video_o.timing <= class_i.timing;
            video_o.rgb    <= rgb;
        end
    end

endmodule

`default_nettype wire

//--- source/tracker_top.sv
`timescale 1ns/1ns
`default_nettype none

module tracker_top #(
    parameter int H_ACTIVE = 64,
    parameter int H_FRONT  = 4,
    parameter int H_SYNC   = 8,
    parameter int H_BACK   = 4,
    parameter int V_ACTIVE = 32,
    parameter int V_FRONT  = 2,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 2
) (
    input  wire                          clk_pixel,
    input  wire                          recent_reset,
    input  wire tracker_pkg::cam_pixel_t cam_i,
    input  wire tracker_pkg::channel_e   channel_i,
    input  wire [7:0]                    lower_i,
    input  wire [7:0]                    upper_i,
    input  wire tracker_pkg::view_e      view_i,
    input  wire                          crosshair_en_i,
    output tracker_pkg::video_out_t      video_o
);
    import tracker_pkg::*;

    video_timing_t      timing_raw;     // Straight from the raster counters
    video_timing_t      timing_fb;      // Aligned with the buffer read
    pixel565_t          pixel_fb;
    classified_t        class_w;
    logic [COORD_W-1:0] com_x;
    logic [COORD_W-1:0] com_y;

    video_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) timing_gen (
        .clk_pixel    (clk_pixel),
        .recent_reset (recent_reset),
        .timing_o     (timing_raw)
    );

    frame_buffer #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE)
    ) fbuf (
        .clk_pixel    (clk_pixel),
        .recent_reset (recent_reset),
        .cam_i        (cam_i),
        .timing_i     (timing_raw),
        .timing_o     (timing_fb),
        .pixel_o      (pixel_fb)
    );

    pixel_classifier classifier (
        .clk_pixel    (clk_pixel),
        .recent_reset (recent_reset),
        .timing_i     (timing_fb),
        .pixel_i      (pixel_fb),
        .channel_i    (channel_i),
        .lower_i      (lower_i),
        .upper_i      (upper_i),
        .class_o      (class_w)
    );

    centroid_tracker tracker (
        .clk_pixel    (clk_pixel),
        .recent_reset (recent_reset),
        .class_i      (class_w),
        .com_x_o      (com_x),
        .com_y_o      (com_y)
    );

    display_mux out_mux (
        .clk_pixel      (clk_pixel),
        .recent_reset   (recent_reset),
        .class_i        (class_w),
        .com_x_i        (com_x),
        .com_y_i        (com_y),
        .view_i         (view_i),
        .crosshair_en_i (crosshair_en_i),
        .video_o        (video_o)
    );

endmodule

`default_nettype wire

//--- tests/clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clock_gen #(
    parameter int RESET_CYCLES = 10
) (
    output logic clk_pixel,
    output logic recent_reset
);

    initial begin
        clk_pixel = 1'b0;
        forever #5 clk_pixel = ~clk_pixel;  // 10 ns period
    end

    initial begin
        recent_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_pixel);
        recent_reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- tests/tracker_properties.sv
`timescale 1ns/1ns
`default_nettype none

module tracker_properties #(
    parameter int H_ACTIVE = 64,
    parameter int V_ACTIVE = 32
) (
    input wire                          clk_pixel,
    input wire                          recent_reset,
    input wire tracker_pkg::video_out_t video_i
);
    import tracker_pkg::*;

    // Picture and sync pulses never overlap
    active_not_in_sync: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        video_i.timing.active |-> !(video_i.timing.hsync || video_i.timing.vsync))
        else $error("active overlaps a sync pulse");

    active_inside_area: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        video_i.timing.active |-> (video_i.timing.hcount < H_ACTIVE)
                               && (video_i.timing.vcount < V_ACTIVE))
        else $error("active outside the visible area");

    blank_is_black: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        !video_i.timing.active |-> (video_i.rgb == '0))
        else $error("colour present during blanking");

endmodule

bind tracker_top tracker_properties #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE)
) props_i (
    .clk_pixel    (clk_pixel),
    .recent_reset (recent_reset),
    .video_i      (video_o)
);

`default_nettype wire

//--- tests/tracker_tb.sv
`timescale 1ns/1ns
`default_nettype none

module tracker_tb;
    import tracker_pkg::*;

    localparam int H_ACTIVE = 64;
    localparam int H_FRONT  = 4;
    localparam int H_SYNC   = 8;
    localparam int H_BACK   = 4;
    localparam int V_ACTIVE = 32;
    localparam int V_FRONT  = 2;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 2;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int WAIT_LIMIT   = 2 * FRAME_CYCLES;

    logic       clk_pixel;
    logic       recent_reset;
    cam_pixel_t cam;
    channel_e   channel;
    logic [7:0] lower;
    logic [7:0] upper;
    view_e      view;
    logic       crosshair_en;
    video_out_t video;

    pixel565_t  cam_frame [0:V_ACTIVE-1][0:H_ACTIVE-1];  // Full camera frame as sent
    integer     seed       = 32'hf6c;
    int         errors     = 0;
    int         checked    = 0;
    int         com_x_now  = 0;  // Centre drawn in the frame on screen
    int         com_y_now  = 0;
    int         com_x_next = 0;  // Centre of the frame on screen and drawn in the next one
    int         com_y_next = 0;

    clock_gen clocks (
        .clk_pixel    (clk_pixel),
        .recent_reset (recent_reset)
    );

    tracker_top #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) dut_i (
        .clk_pixel      (clk_pixel),
        .recent_reset   (recent_reset),
        .cam_i          (cam),
        .channel_i      (channel),
        .lower_i        (lower),
        .upper_i        (upper),
        .view_i         (view),
        .crosshair_en_i (crosshair_en),
        .video_o        (video)
    );

    task automatic report_timeout(input string what);
        $display("Timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on timeout");
    endtask

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        checked++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "simulation stopped at first mismatch");
        end
    endtask

    // Raster fields for a position in the full line and frame
    function automatic video_timing_t expected_timing(input int h, input int v);
        video_timing_t t;
        t.hcount    = COORD_W'(h);
        t.vcount    = COORD_W'(v);
        t.hsync     = (h >= H_ACTIVE + H_FRONT) && (h < H_ACTIVE + H_FRONT + H_SYNC);
        t.vsync     = (v >= V_ACTIVE + V_FRONT) && (v < V_ACTIVE + V_FRONT + V_SYNC);
        t.active    = (h < H_ACTIVE) && (v < V_ACTIVE);
        t.new_frame = (h == 0) && (v == 0);
        return t;
    endfunction

    // Each 4x4 block shows the camera pixel at its top-left corner
    function automatic pixel565_t stored_pixel(input int h, input int v);
        return cam_frame[v - (v % 4)][h - (h % 4)];
    endfunction

    function automatic logic [7:0] channel_value(input pixel565_t p, input channel_e ch);
        case (ch)
            CH_RED:   return p.r * 8;
            CH_GREEN: return p.g * 4;
            default:  return p.b * 8;
        endcase
    endfunction

    function automatic logic in_window(input logic [7:0] val);
        return (val >= lower) && (val <= upper);
    endfunction

    function automatic rgb888_t expected_rgb(input int h, input int v, input int cx, input int cy);
        pixel565_t  p;
        logic [7:0] val;
        rgb888_t    rgb;
        if (h >= H_ACTIVE || v >= V_ACTIVE) begin
            return '0;
        end
        p   = stored_pixel(h, v);
        val = channel_value(p, channel);
        case (view)
            VIEW_CAMERA: begin
                rgb.r = p.r * 8;
                rgb.g = p.g * 4;
                rgb.b = p.b * 8;
            end
            VIEW_CHANNEL: rgb = {val, val, val};
            default:      rgb = in_window(val) ? 24'hFFFFFF : 24'h000000;
        endcase
        if (crosshair_en && (h == cx || v == cy)) begin
            rgb = 24'hFFFFFF;
        end
        return rgb;
    endfunction

    // Floor mean of the masked display coordinates unless nothing is masked
    task automatic update_centre();
        longint sx;
        longint sy;
        longint n;
        sx = 0;
        sy = 0;
        n  = 0;
        for (int v = 0; v < V_ACTIVE; v++) begin
            for (int h = 0; h < H_ACTIVE; h++) begin
                if (in_window(channel_value(stored_pixel(h, v), channel))) begin
                    sx += h;
                    sy += v;
                    n++;
                end
            end
        end
        if (n != 0) begin
            com_x_next = int'(sx / n);
            com_y_next = int'(sy / n);
        end
    endtask

    task automatic load_camera();
        for (int v = 0; v < V_ACTIVE; v++) begin
            for (int h = 0; h < H_ACTIVE; h++) begin
                @(posedge clk_pixel);
                cam.valid  <= 1'b1;
                cam.hcount <= COORD_W'(h);
                cam.vcount <= COORD_W'(v);
                cam.pixel  <= cam_frame[v][h];
            end
        end
        @(posedge clk_pixel);
        cam.valid <= 1'b0;
    endtask

    task automatic wait_frames(input int n);
        int waited;
        for (int i = 0; i < n; i++) begin
            waited = 0;
            do begin
                @(posedge clk_pixel);
                waited++;
                if (waited > WAIT_LIMIT) begin
                    report_timeout("new_frame on video_o");
                end
            end while (!video.timing.new_frame);
        end
    endtask

    task automatic wait_blanking();
        int waited;
        waited = 0;
        do begin
            @(posedge clk_pixel);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("vertical blanking on video_o");
            end
        end while (video.timing.vcount != V_ACTIVE);
    endtask

    // Settings change only in blanking and stay for two whole frames
    task automatic hold_settings(input channel_e ch, input logic [7:0] lo, input logic [7:0] up,
                                 input view_e vw, input logic xh);
        wait_blanking();
        channel      <= ch;
        lower        <= lo;
        upper        <= up;
        view         <= vw;
        crosshair_en <= xh;
        wait_frames(2);
    endtask

    initial begin : drive_stimulus
        int          waited;
        logic [31:0] word;
        cam          = '0;
        channel      = CH_RED;
        lower        = 8'h00;
        upper        = 8'hFF;
        view         = VIEW_CAMERA;
        crosshair_en = 1'b0;
        for (int v = 0; v < V_ACTIVE; v++) begin
            for (int h = 0; h < H_ACTIVE; h++) begin
                word            = $random(seed);
                cam_frame[v][h] = word[15:0];
            end
        end
        waited = 0;
        do begin
            @(posedge clk_pixel);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("release of recent_reset");
            end
        end while (recent_reset);

        load_camera();
        wait_frames(2);  // Camera view, crosshair off
        hold_settings(CH_RED,   8'h00, 8'hFF, VIEW_CHANNEL, 1'b0);
        hold_settings(CH_GREEN, 8'h00, 8'hFF, VIEW_CHANNEL, 1'b0);
        hold_settings(CH_BLUE,  8'h00, 8'hFF, VIEW_CHANNEL, 1'b0);
        hold_settings(CH_GREEN, 8'h40, 8'hC0, VIEW_MASK,    1'b0);
        hold_settings(CH_RED,   8'h80, 8'h80, VIEW_MASK,    1'b0);  // Single value window
        hold_settings(CH_BLUE,  8'h00, 8'h3F, VIEW_MASK,    1'b0);
        hold_settings(CH_GREEN, 8'h20, 8'h9F, VIEW_CAMERA,  1'b1);
        hold_settings(CH_GREEN, 8'hFF, 8'h00, VIEW_MASK,    1'b1);  // Empty window
        wait_blanking();

        if (errors == 0 && checked > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("No video words were compared");
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin : compare_output
        int waited;
        int frames;
        int active_words;
        int h;
        int v;
        int exp_h;
        int exp_v;
        waited       = 0;
        frames       = 0;
        active_words = 0;
        exp_h        = 0;
        exp_v        = 0;
        do begin
            @(negedge clk_pixel);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("release of recent_reset");
            end
        end while (recent_reset);

        forever begin
            h = video.timing.hcount;
            v = video.timing.vcount;
            if (video.timing.new_frame) begin
                if (frames >= 1) begin
                    check_equal(active_words, H_ACTIVE * V_ACTIVE, "active words per frame");
                end else begin
                    exp_h = 0;  // First frame start fixes the raster position
                    exp_v = 0;
                end
                frames++;
                active_words = 0;
                com_x_now    = com_x_next;
                com_y_now    = com_y_next;
            end
            if (frames == 0) begin
                check_equal(video, '0, "video_o before the first frame");
            end else begin
                check_equal(video.timing, expected_timing(exp_h, exp_v),
                            $sformatf("timing at (%0d,%0d)", exp_h, exp_v));
                if (exp_h == H_TOTAL - 1) begin
                    exp_h = 0;
                    exp_v = (exp_v == V_TOTAL - 1) ? 0 : exp_v + 1;
                end else begin
                    exp_h++;
                end
            end
            if (video.timing.active) begin
                active_words++;
            end
            if (frames >= 3) begin
                check_equal(video.rgb, expected_rgb(h, v, com_x_now, com_y_now),
                            $sformatf("rgb at (%0d,%0d)", h, v));
            end
            // Last visible pixel closes the frame for the centre
            if (video.timing.active && h == H_ACTIVE - 1 && v == V_ACTIVE - 1) begin
                update_centre();
            end
            @(negedge clk_pixel);
        end
    end

endmodule

`default_nettype wire

//--- tracker_top.f
source/tracker_pkg.sv
source/video_timing.sv
source/frame_buffer.sv
source/pixel_classifier.sv
source/centroid_tracker.sv
source/display_mux.sv
source/tracker_top.sv
tests/clock_gen.sv
tests/tracker_properties.sv
tests/tracker_tb.sv
